//--- tb.f
hw/isa_pkg.sv
hw/ctrl_pkg.sv
hw/alu.sv
hw/controller.sv
hw/datapath.sv
hw/core_top.sv
tb/core_checker.sv
tb/tb_top.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_top
FILELIST  = tb.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove build output"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

//--- tb/tb_top.sv
module tb_top
    import isa_pkg::*;
    import ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic              clk;
    logic              rstn;
    logic [addr_w-1:0] imem_addr;
    word_t             imem_data = '0;
    dmem_req_t         dmem;
    word_t             dmem_rdata = '0;
    logic              tx_req;
    logic              tx_ack;
    logic [7:0]        tx_data;
    logic              halted;
    logic              prog_ready;
    logic              check_done;
    logic              check_ok;
    logic [addr_w-1:0] imem_q = '0;
    logic [addr_w-1:0] dmem_q = '0;

    word_t imem [2**addr_w];
    word_t dram [2**addr_w];
    int    n;   // next free instruction slot

    function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3, reg_idx_t rd, opcode_e op);
        return {f7, rs2, rs1, f3, rd, op, 2'b11};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                     reg_idx_t rd, opcode_e op);
        return {imm, rs1, f3, rd, op, 2'b11};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store, 2'b11};
    endfunction

    function automatic word_t b_type(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch, 2'b11};
    endfunction

    function automatic word_t u_type(logic [19:0] imm, reg_idx_t rd, opcode_e op);
        return {imm, rd, op, 2'b11};
    endfunction

    function automatic word_t j_type(logic [20:0] off, reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal, 2'b11};
    endfunction

    task automatic put(word_t w);
        imem[n] = w;
        n++;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (2) @(negedge clk);
        rstn = 1'b1;
    end

    // synchronous memories, read data valid from the falling edge after the address
    always @(posedge clk) begin
        imem_q <= imem_addr;
        dmem_q <= dmem.addr;
        if (dmem.we)
            dram[dmem.addr] <= dmem.wdata;
    end

    always @(negedge clk) begin
        imem_data  = imem[imem_q];
        dmem_rdata = dram[dmem_q];
    end

    // four-phase ack with a random delay
    initial begin
        int d;
        tx_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (tx_req && !tx_ack) begin
                d = $urandom_range(0, 3);
                repeat (d) @(negedge clk);
                tx_ack = 1'b1;
                while (tx_req)
                    @(negedge clk);
                tx_ack = 1'b0;
            end
        end
    end

    initial begin
        int          k;
        int          jal_at;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        prog_ready = 1'b0;
        void'($urandom(32'hec42));
        for (int i = 0; i < 2**addr_w; i++) begin
            imem[i] = '0;
            dram[i] = {i[11:0], ~i[11:0], 8'h5a};
        end
        n = 0;
        k = 0;
        for (int r = 1; r < 8; r++) begin
            put(u_type(20'($urandom()), reg_idx_t'(r), op_lui));
            put(i_type(12'($urandom()), reg_idx_t'(r), 3'd0, reg_idx_t'(r), op_arith_imm));
        end
        put(i_type(12'd256, 5'd0, 3'd0, 5'd8, op_arith_imm));   // x8 is the store base
        repeat (10) begin
            rd  = reg_idx_t'($urandom_range(1, 7));
            rs1 = reg_idx_t'($urandom_range(1, 7));
            rs2 = reg_idx_t'($urandom_range(1, 7));
            f3  = 3'($urandom());
            alt = $urandom_range(0, 1) == 1 && (f3 == 3'd0 || f3 == 3'd5);
            if ($urandom_range(0, 1) == 1) begin
                put(r_type(alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, op_arith));
            end else begin
                imm = 12'($urandom());
                if (f3 == 3'd1)
                    imm = {7'h00, imm[4:0]};
                if (f3 == 3'd5)
                    imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
                put(i_type(imm, rs1, f3, rd, op_arith_imm));
            end
            put(s_type(12'(4 * k), rd, 5'd8));
            k++;
        end
        put(u_type(20'($urandom()), 5'd5, op_auipc));
        put(s_type(12'(4 * k), 5'd5, 5'd8));
        k++;
        put(i_type(12'd0, 5'd8, 3'b010, 5'd6, op_load));
        put(i_type(12'd4, 5'd8, 3'b010, 5'd7, op_load));
        put(r_type(7'h20, 5'd7, 5'd6, 3'd0, 5'd5, op_arith));
        put(s_type(12'(4 * k), 5'd5, 5'd8));
        k++;
        // counted loop, three passes
        put(i_type(12'd3, 5'd0, 3'd0, 5'd1, op_arith_imm));
        put(i_type(12'd5, 5'd2, 3'd0, 5'd2, op_arith_imm));
        put(i_type(12'hfff, 5'd1, 3'd0, 5'd1, op_arith_imm));
        put(b_type(13'h1ff8, 5'd0, 5'd1, 3'b001));
        put(s_type(12'(4 * k), 5'd2, 5'd8));
        k++;
        put(i_type(12'd0, 5'd2, 3'd0, 5'd0, op_tx));
        // beq, blt, bge each skip one add when taken
        put(b_type(13'd8, 5'd4, 5'd3, 3'b000));
        put(i_type(12'd1, 5'd5, 3'd0, 5'd5, op_arith_imm));
        put(b_type(13'd8, 5'd4, 5'd3, 3'b100));
        put(i_type(12'd2, 5'd5, 3'd0, 5'd5, op_arith_imm));
        put(b_type(13'd8, 5'd4, 5'd3, 3'b101));
        put(i_type(12'd4, 5'd5, 3'd0, 5'd5, op_arith_imm));
        put(s_type(12'(4 * k), 5'd5, 5'd8));
        k++;
        jal_at = n;
        put('0);   // patched below
        put(i_type(12'd0, 5'd3, 3'd0, 5'd0, op_tx));
        put(s_type(12'(4 * k), 5'd1, 5'd8));   // link value
        put('0);
        imem[jal_at] = j_type(21'((n - jal_at) * 4), 5'd1);
        put(i_type(12'd7, 5'd6, 3'd0, 5'd6, op_arith_imm));
        put(i_type(12'd0, 5'd6, 3'd0, 5'd0, op_tx));
        put(i_type(12'd0, 5'd1, 3'd0, 5'd0, op_jalr));
        prog_ready = 1'b1;
    end

    initial begin
        wait (check_done);
        if (check_ok)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    core_top DUT (
        .clk        (clk),
        .rstn       (rstn),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem       (dmem),
        .dmem_rdata (dmem_rdata),
        .tx_req     (tx_req),
        .tx_ack     (tx_ack),
        .tx_data    (tx_data),
        .halted     (halted)
    );

    core_checker u_checker (
        .clk        (clk),
        .rstn       (rstn),
        .dmem       (dmem),
        .tx_req     (tx_req),
        .tx_ack     (tx_ack),
        .tx_data    (tx_data),
        .halted     (halted),
        .prog_ready (prog_ready),
        .done       (check_done),
        .all_ok     (check_ok)
    );

endmodule

//--- tb/core_checker.sv
module core_checker
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  dmem_req_t  dmem,
    input  logic       tx_req,
    input  logic       tx_ack,
    input  logic [7:0] tx_data,
    input  logic       halted,
    input  logic       prog_ready,
    output logic       done,
    output logic       all_ok
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [43:0] exp_stores [$];   // {word address, data}
    logic [7:0]  exp_bytes [$];
    int          value_errs = 0;
    int          proto_errs = 0;
    int          n_stores = 0;
    int          n_bytes = 0;
    int          limit;
    int          cycles;
    logic        prev_req = 1'b0;
    logic        ack_seen = 1'b0;
    logic        halt_seen = 1'b0;
    logic [7:0]  held;

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return word_t'($signed(a) < $signed(b));
            3'd3:    return word_t'(a < b);
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // runs the program from instruction memory, returns the instruction count
    function automatic int run_program();
        word_t       x [32];
        word_t       mem [int];
        word_t       pc;
        word_t       ins;
        word_t       immi;
        word_t       imms;
        word_t       immb;
        word_t       immj;
        word_t       addr;
        logic [2:0]  f3;
        logic [4:0]  rd;
        int          steps;
        logic        take;
        for (int i = 0; i < 32; i++)
            x[i] = '0;
        pc = '0;
        steps = 0;
        while (steps < 5000) begin
            ins = tb_top.imem[pc[13:2]];
            steps++;
            if (ins == '0)
                break;
            f3   = ins[14:12];
            rd   = ins[11:7];
            immi = {{20{ins[31]}}, ins[31:20]};
            imms = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immb = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            immj = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            case (ins[6:2])
                5'h0d: x[rd] = {ins[31:12], 12'b0};
                5'h05: x[rd] = pc + {ins[31:12], 12'b0};
                5'h04: x[rd] = alu_ref(f3, ins[30] && f3 == 3'd5, x[ins[19:15]], immi);
                5'h0c: x[rd] = alu_ref(f3, ins[30], x[ins[19:15]], x[ins[24:20]]);
                5'h00: begin
                    addr  = (x[ins[19:15]] + immi) >> 2;
                    x[rd] = mem[int'(addr[11:0])];
                end
                5'h08: begin
                    addr = (x[ins[19:15]] + imms) >> 2;
                    mem[int'(addr[11:0])] = x[ins[24:20]];
                    exp_stores.push_back({addr[11:0], x[ins[24:20]]});
                end
                5'h06: exp_bytes.push_back(x[ins[19:15]][7:0]);
                default: ;
            endcase
            take = 1'b0;
            case (ins[6:2])
                5'h18: begin
                    case (f3)
                        3'b000:  take = x[ins[19:15]] == x[ins[24:20]];
                        3'b001:  take = x[ins[19:15]] != x[ins[24:20]];
                        3'b100:  take = $signed(x[ins[19:15]]) < $signed(x[ins[24:20]]);
                        default: take = $signed(x[ins[19:15]]) >= $signed(x[ins[24:20]]);
                    endcase
                    pc = take ? pc + immb : pc + 4;
                end
                5'h1b: begin
                    x[rd] = pc + 4;
                    pc = pc + immj;
                end
                5'h19: begin
                    addr  = x[ins[19:15]] + immi;
                    x[rd] = pc + 4;
                    pc = addr;
                end
                default: pc = pc + 4;
            endcase
            x[0] = '0;
        end
        return steps;
    endfunction

    always @(posedge clk) begin
        if (rstn && prog_ready) begin
            if (dmem.we) begin
                if (halt_seen) begin
                    $display("store issued after the core halted");
                    proto_errs++;
                end
                if (n_stores >= exp_stores.size()) begin
                    $display("store not expected by the reference program");
                    value_errs++;
                end else if ({dmem.addr, dmem.wdata} != exp_stores[n_stores]) begin
                    $display("error store %0d: expected %h, actual %h", n_stores,
                             exp_stores[n_stores], {dmem.addr, dmem.wdata});
                    value_errs++;
                end
                n_stores++;
            end
            if (tx_req && !prev_req) begin
                if (tx_ack) begin
                    $display("new tx_req raised while tx_ack still high");
                    proto_errs++;
                end
                if (halt_seen) begin
                    $display("transmit issued after the core halted");
                    proto_errs++;
                end
                if (n_bytes >= exp_bytes.size()) begin
                    $display("byte transmitted that the reference program does not send");
                    value_errs++;
                end else if (tx_data != exp_bytes[n_bytes]) begin
                    $display("error tx byte %0d: expected %h, actual %h", n_bytes,
                             exp_bytes[n_bytes], tx_data);
                    value_errs++;
                end
                held     = tx_data;
                ack_seen = 1'b0;
                n_bytes++;
            end else if (tx_req && tx_data != held) begin
                $display("tx_data changed while tx_req was high");
                proto_errs++;
            end
            if (!tx_req && prev_req && !ack_seen) begin
                $display("tx_req dropped before tx_ack was seen");
                proto_errs++;
            end
            if (tx_req && tx_ack)
                ack_seen = 1'b1;
            prev_req  = tx_req;
            halt_seen = halted;
        end
    end

    initial begin
        done   = 1'b0;
        all_ok = 1'b0;
        wait (prog_ready);
        limit  = 12 * run_program() + 40;
        cycles = 0;
        wait (rstn);
        while (!halted && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("timeout: core did not halt within %0d cycles", limit);
        end else begin
            repeat (10) @(posedge clk);
            if (n_stores != exp_stores.size()) begin
                $display("error store count: expected %0d, actual %0d",
                         exp_stores.size(), n_stores);
                value_errs++;
            end
            if (n_bytes != exp_bytes.size()) begin
                $display("error byte count: expected %0d, actual %0d",
                         exp_bytes.size(), n_bytes);
                value_errs++;
            end
        end
        $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
        all_ok = halted && (value_errs + proto_errs == 0);
        done   = 1'b1;
    end

endmodule

//--- hw/core_top.sv
module core_top
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    output logic [addr_w-1:0] imem_addr,
    input  word_t             imem_data,
    output dmem_req_t         dmem,
    input  word_t             dmem_rdata,
    output logic              tx_req,
    input  logic              tx_ack,
    output logic [7:0]        tx_data,
    output logic              halted
);

    ctrl_t ctrl;
    word_t srca;
    word_t srcb;
    word_t alu_res;
    logic  alu_zero;

    controller u_controller (
        .clk      (clk),
        .rstn     (rstn),
        .instr    (imem_data),
        .alu_zero (alu_zero),
        .ctrl     (ctrl),
        .tx_req   (tx_req),
        .tx_ack   (tx_ack),
        .halted   (halted)
    );

    datapath u_datapath (
        .clk        (clk),
        .rstn       (rstn),
        .ctrl       (ctrl),
        .instr      (imem_data),
        .alu_res    (alu_res),
        .srca       (srca),
        .srcb       (srcb),
        .imem_addr  (imem_addr),
        .dmem       (dmem),
        .dmem_rdata (dmem_rdata),
        .tx_data    (tx_data)
    );

    alu u_alu (
        .srca      (srca),
        .srcb      (srcb),
        .op        (ctrl.alu_op),
        .sub_arith (ctrl.sub_arith),
        .res       (alu_res),
        .zero      (alu_zero)
    );

endmodule

//--- hw/datapath.sv
module datapath
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    input  ctrl_t             ctrl,
    input  word_t             instr,
    input  word_t             alu_res,
    output word_t             srca,
    output word_t             srcb,
    output logic [addr_w-1:0] imem_addr,
    output dmem_req_t         dmem,
    input  word_t             dmem_rdata,
    output logic [7:0]        tx_data
);

    word_t  regs [32];
    word_t  pc;
    word_t  a;
    word_t  b;
    word_t  aluout;
    word_t  rs1_val;
    word_t  rs2_val;
    word_t  wdata;
    word_t  imm_i;
    word_t  imm_s;
    word_t  imm_u;
    word_t  imm_sb;
    word_t  imm_uj;
    instr_t ir;

    assign ir = instr;

    // x0 reads as zero
    assign rs1_val = (ir.rs1 == '0) ? '0 : regs[ir.rs1];
    assign rs2_val = (ir.rs2 == '0) ? '0 : regs[ir.rs2];

    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u  = {instr[31:12], 12'b0};
    assign imm_sb = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_uj = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (ctrl.srca_sel)
            srca_pc:  srca = pc;
            srca_rs1: srca = a;
            default:  srca = '0;
        endcase
    end

    always_comb begin
        case (ctrl.srcb_sel)
            srcb_rs2:    srcb = b;
            srcb_four:   srcb = word_t'(4);
            srcb_imm_i:  srcb = imm_i;
            srcb_imm_s:  srcb = imm_s;
            srcb_imm_u:  srcb = imm_u;
            srcb_imm_sb: srcb = imm_sb;
            srcb_imm_uj: srcb = imm_uj;
            default:     srcb = '0;
        endcase
    end

    assign wdata     = (ctrl.wb_sel == wb_mem) ? dmem_rdata : aluout;
    assign imem_addr = pc[addr_w+1:2];
    assign dmem      = '{we: ctrl.mem_write, addr: aluout[addr_w+1:2], wdata: b};
    assign tx_data   = a[7:0];

    always_ff @(posedge clk) begin
        if (!rstn)
            pc <= reset_pc;
        else if (ctrl.pc_write)
            pc <= alu_res;
    end

    always_ff @(posedge clk) begin
        if (ctrl.latch_operands) begin
            a <= rs1_val;
            b <= rs2_val;
        end
        aluout <= alu_res;   // address, link value or result
        if (ctrl.reg_write && ir.rd != '0)
            regs[ir.rd] <= wdata;
    end

endmodule

//--- hw/controller.sv
module controller
    import isa_pkg::*;
    import ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  word_t instr,
    input  logic  alu_zero,
    output ctrl_t ctrl,
    output logic  tx_req,
    input  logic  tx_ack,
    output logic  halted
);

    state_e    state;
    instr_t    ir;
    logic      rd_nz;
    logic      taken;
    srcb_sel_e imm_sel;

    assign ir    = instr;
    assign rd_nz = (ir.rd != '0);
    // beq/bne on the difference, blt/bge on the less-than result
    assign taken = alu_zero ^ ir.funct3[0] ^ (ctrl.alu_op != alu_add_sub);

    always_comb begin
        case (ir.opcode)
            op_store:         imm_sel = srcb_imm_s;
            op_lui, op_auipc: imm_sel = srcb_imm_u;
            op_branch:        imm_sel = srcb_imm_sb;
            op_jal:           imm_sel = srcb_imm_uj;
            default:          imm_sel = srcb_imm_i;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state  <= s_init;
            ctrl   <= '0;
            tx_req <= 1'b0;
            halted <= 1'b0;
        end else begin
            ctrl.pc_write       <= 1'b0;   // all strobes last one state
            ctrl.reg_write      <= 1'b0;
            ctrl.mem_write      <= 1'b0;
            ctrl.latch_operands <= 1'b0;
            case (state)
                s_init, s_nextpc: state <= s_fetch;
                s_fetch: begin
                    state               <= s_decode;
                    ctrl.latch_operands <= 1'b1;
                end
                s_decode: begin
                    ctrl.srca_sel  <= srca_rs1;
                    ctrl.srcb_sel  <= imm_sel;
                    ctrl.alu_op    <= alu_add_sub;
                    ctrl.sub_arith <= 1'b0;
                    if (instr == '0) begin
                        state  <= s_halt;
                        halted <= 1'b1;
                    end else begin
                        case (ir.opcode)
                            op_load, op_store: state <= s_memaddr;
                            op_tx: begin
                                state  <= s_transmit;
                                tx_req <= 1'b1;
                            end
                            op_arith_imm: begin
                                state          <= s_arimm_exec;
                                ctrl.alu_op    <= alu_op_e'(ir.funct3);
                                ctrl.sub_arith <= ir.funct7[5] && (ir.funct3 == alu_shift_r);
                            end
                            op_arith: begin
                                state          <= s_ari_exec;
                                ctrl.srcb_sel  <= srcb_rs2;
                                ctrl.alu_op    <= alu_op_e'(ir.funct3);
                                ctrl.sub_arith <= ir.funct7[5];
                            end
                            op_branch: begin
                                state          <= s_compare;
                                ctrl.srcb_sel  <= srcb_rs2;
                                ctrl.alu_op    <= alu_op_e'({1'b0, ir.funct3[2:1]});
                                ctrl.sub_arith <= 1'b1;
                            end
                            op_lui: begin
                                state         <= s_lui_read;
                                ctrl.srca_sel <= srca_zero;
                            end
                            op_auipc: begin
                                state         <= s_auipc_read;
                                ctrl.srca_sel <= srca_pc;
                            end
                            op_jal, op_jalr: begin
                                state         <= s_link_rd;   // pc + 4 first
                                ctrl.srca_sel <= srca_pc;
                                ctrl.srcb_sel <= srcb_four;
                            end
                            default: begin
                                state  <= s_halt;
                                halted <= 1'b1;
                            end
                        endcase
                    end
                end
                s_memaddr: begin
                    if (ir.opcode == op_store) begin
                        state          <= s_memwrite;
                        ctrl.mem_write <= 1'b1;
                    end else begin
                        state <= s_memread;
                    end
                end
                s_memread: begin
                    state          <= s_writeback;
                    ctrl.reg_write <= rd_nz;
                    ctrl.wb_sel    <= wb_mem;
                end
                s_arimm_exec, s_ari_exec, s_lui_read, s_auipc_read: begin
                    state          <= s_alu_wb;
                    ctrl.reg_write <= rd_nz;
                    ctrl.wb_sel    <= wb_alu;
                end
                s_compare: begin
                    state          <= s_branch;
                    ctrl.pc_write  <= 1'b1;
                    ctrl.srca_sel  <= srca_pc;
                    ctrl.srcb_sel  <= taken ? srcb_imm_sb : srcb_four;
                    ctrl.alu_op    <= alu_add_sub;
                    ctrl.sub_arith <= 1'b0;
                end
                s_link_rd: begin
                    state          <= s_jump;
                    ctrl.pc_write  <= 1'b1;
                    ctrl.reg_write <= rd_nz;   // link value sits in aluout
                    ctrl.wb_sel    <= wb_alu;
                    ctrl.srca_sel  <= (ir.opcode == op_jal) ? srca_pc : srca_rs1;
                    ctrl.srcb_sel  <= imm_sel;
                end
                s_transmit: begin
                    if (tx_ack) begin
                        state  <= s_tx_release;
                        tx_req <= 1'b0;
                    end
                end
                s_writeback, s_memwrite, s_alu_wb, s_tx_release: begin
                    if (state != s_tx_release || !tx_ack) begin
                        state          <= s_nextpc;
                        ctrl.pc_write  <= 1'b1;
                        ctrl.srca_sel  <= srca_pc;
                        ctrl.srcb_sel  <= srcb_four;
                        ctrl.alu_op    <= alu_add_sub;
                        ctrl.sub_arith <= 1'b0;
                    end
                end
                s_branch, s_jump: state <= s_nextpc;   // pc already written
                default: state <= s_halt;
            endcase
        end
    end

    a_tx_req_fall: assert property (@(posedge clk) disable iff (!rstn)
        $fell(tx_req) |-> $past(tx_ack))
        else $error("tx_req dropped before tx_ack was seen");

    a_pc_write_pulse: assert property (@(posedge clk) disable iff (!rstn)
        ctrl.pc_write |=> !ctrl.pc_write)
        else $error("pc_write held for more than one cycle");

endmodule

//--- hw/alu.sv
module alu
    import isa_pkg::*;
(
    input  word_t   srca,
    input  word_t   srcb,
    input  alu_op_e op,
    input  logic    sub_arith,
    output word_t   res,
    output logic    zero
);

    logic [4:0] shamt;

    assign shamt = srcb[4:0];

    always_comb begin
        case (op)
            alu_add_sub: res = sub_arith ? srca - srcb : srca + srcb;
            alu_shift_l: res = srca << shamt;
            alu_lt:      res = {{(xlen-1){1'b0}}, $signed(srca) < $signed(srcb)};
            alu_lt_u:    res = {{(xlen-1){1'b0}}, srca < srcb};
            alu_xor:     res = srca ^ srcb;
            alu_shift_r: begin
                // arithmetic or logical
                if (sub_arith)
                    res = $signed(srca) >>> shamt;
                else
                    res = srca >> shamt;
            end
            alu_or:      res = srca | srcb;
            default:     res = srca & srcb;
        endcase
    end

    assign zero = (res == '0);  // branch compare uses this

    // op must be known whenever operand b is
    always_comb begin
        if (!$isunknown(srcb)) begin
            assert (!$isunknown(op)) else $error("alu: operation unknown with valid operand b");
        end
    end

endmodule

//--- hw/ctrl_pkg.sv
package ctrl_pkg;
    import isa_pkg::*;

    localparam int    addr_w   = 12;   // word address bits
    localparam word_t reset_pc = '0;

    typedef enum logic [4:0] {
        s_nextpc     = 5'h00,
        s_fetch      = 5'h01,
        s_decode     = 5'h03,
        s_memaddr    = 5'h04,
        s_memread    = 5'h05,
        s_writeback  = 5'h06,
        s_memwrite   = 5'h07,
        s_transmit   = 5'h08,
        s_arimm_exec = 5'h09,
        s_alu_wb     = 5'h0a,
        s_ari_exec   = 5'h0b,
        s_compare    = 5'h0c,
        s_branch     = 5'h0d,
        s_lui_read   = 5'h0e,
        s_auipc_read = 5'h0f,
        s_link_rd    = 5'h10,
        s_jump       = 5'h11,
        s_tx_release = 5'h12,
        s_halt       = 5'h1e,
        s_init       = 5'h1f
    } state_e;

    typedef enum logic [1:0] {
        srca_pc   = 2'd0,
        srca_rs1  = 2'd1,
        srca_zero = 2'd2
    } srca_sel_e;

    typedef enum logic [2:0] {
        srcb_rs2    = 3'd0,
        srcb_four   = 3'd1,
        srcb_imm_i  = 3'd2,
        srcb_imm_s  = 3'd3,
        srcb_imm_u  = 3'd4,
        srcb_imm_sb = 3'd5,
        srcb_imm_uj = 3'd6
    } srcb_sel_e;

    typedef enum logic {
        wb_alu = 1'b0,
        wb_mem = 1'b1
    } wb_sel_e;

    typedef struct packed {
        logic      pc_write;
        logic      reg_write;
        logic      mem_write;
        wb_sel_e   wb_sel;
        srca_sel_e srca_sel;
        srcb_sel_e srcb_sel;
        alu_op_e   alu_op;
        logic      sub_arith;       // sub for add_sub, arithmetic for shift_r
        logic      latch_operands;  // decode only
    } ctrl_t;

    typedef struct packed {
        logic              we;
        logic [addr_w-1:0] addr;
        word_t             wdata;
    } dmem_req_t;

endpackage

//--- hw/isa_pkg.sv
package isa_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // major opcode, instr[6:2]
    typedef enum logic [4:0] {
        op_load      = 5'h00,
        op_arith_imm = 5'h04,
        op_auipc     = 5'h05,
        op_tx        = 5'h06,
        op_store     = 5'h08,
        op_arith     = 5'h0c,
        op_lui       = 5'h0d,
        op_branch    = 5'h18,
        op_jalr      = 5'h19,
        op_jal       = 5'h1b
    } opcode_e;

    // matches funct3 of the alu instructions
    typedef enum logic [2:0] {
        alu_add_sub = 3'b000,
        alu_shift_l = 3'b001,
        alu_lt      = 3'b010,
        alu_lt_u    = 3'b011,
        alu_xor     = 3'b100,
        alu_shift_r = 3'b101,
        alu_or      = 3'b110,
        alu_and     = 3'b111
    } alu_op_e;

    // r-type layout; immediates are cut from the raw word
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
        logic [1:0] quadrant;   // always 2'b11
    } instr_t;

endpackage
